// ==== hdl/cmd_pkg.sv ====
package cmd_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths that carry a meaning
	typedef logic [31:0] word_t;          // one stream word
	typedef logic [4:0]  cmd_code_t;      // low bits of the command word
	typedef logic [31:0] reg_num_t;       // register number as received
	typedef logic [15:0] tag_t;           // channel tag
	typedef logic [20:0] burst_count_t;   // burst counts per fill type
	typedef logic [23:0] fill_num_t;      // fill numbers
	typedef logic [2:0]  ch_addr_t;       // channel address jumpers

	// work entries handed from decoder to responder
	typedef enum logic [2:0] {
		ek_word,       // send word unchanged
		ek_reg_rd,     // word is a register number to read
		ek_wr_num,     // latch register number for a write
		ek_wr_data,    // write word to latched register
		ek_trailer     // word or its inverse on frame error
	} entry_kind_t;

	////////////////////////////////////////////////////////////////////////////
	// command codes
	localparam cmd_code_t cc_loopback = 5'd1;
	localparam cmd_code_t cc_rd_reg   = 5'd2;
	localparam cmd_code_t cc_wr_reg   = 5'd3;

	// register map
	localparam reg_num_t reg_channel_tag  = 32'd0;
	localparam reg_num_t reg_muon_bursts  = 32'd1;
	localparam reg_num_t reg_laser_bursts = 32'd2;
	localparam reg_num_t reg_ped_bursts   = 32'd3;
	localparam reg_num_t reg_initial_fill = 32'd4;
	localparam reg_num_t reg_fill_num     = 32'd5;   // read only
	localparam reg_num_t reg_ch_addr      = 32'd6;   // read only
	localparam reg_num_t num_regs         = 32'd7;

	localparam int queue_depth = 16;   // entries between decoder and responder

	////////////////////////////////////////////////////////////////////////////
	// state machines
	typedef enum logic [3:0] {ds_init, ds_serial, ds_command, ds_payload, ds_rd_arg,
		ds_wr_num, ds_wr_data, ds_trailer, ds_err, ds_drain} decoder_state_t;
	typedef enum logic {rs_empty, rs_full} responder_state_t;

endpackage

// ==== hdl/cmd_entry_if.sv ====
`timescale 1ns/1ps

// one work entry per handshake, valid/ready
interface cmd_entry_if;
	import cmd_pkg::*;

	logic        valid;   // entry on offer
	logic        ready;   // consumer takes it this cycle
	word_t       word;    // data word of the entry
	entry_kind_t kind;    // what the responder does with it
	logic        last;    // word closes a response frame

	modport producer (
		output valid, word, kind, last,
		input  ready
	);

	modport consumer (
		input  valid, word, kind, last,
		output ready
	);

endinterface

// ==== hdl/reg_access_if.sv ====
`timescale 1ns/1ps

interface reg_access_if;
	import cmd_pkg::*;

	reg_num_t reg_num;   // selected register
	logic     wr_en;     // write strobe, one cycle per write
	word_t    wr_data;
	word_t    rd_data;   // zero extended register value
	logic     illegal;   // bad number, or write to a read-only register

	modport requester (output reg_num, wr_en, wr_data, input rd_data, illegal);
	modport bank (input reg_num, wr_en, wr_data, output rd_data, illegal);

endinterface

// ==== hdl/cmd_decoder.sv ====
`timescale 1ns/1ps

module cmd_decoder (
	input  logic           clk,
	input  logic           reset,
	input  cmd_pkg::word_t rx_data,
	input  logic           rx_tvalid,
	input  logic           rx_tlast,
	output logic           rx_tready,
	cmd_entry_if.producer  entries
);
	import cmd_pkg::*;

	decoder_state_t state;
	word_t          cmd_q;     // command word of the frame in progress
	logic           ended_q;   // last accepted word carried rx_tlast
	cmd_code_t      rx_code;
	logic           take;      // this state consumes a receive word
	logic           accept;

	assign rx_code = rx_data[4:0];

	// trailer and error states push from cmd_q and hold the receive side off
	assign take = (state != ds_init) && (state != ds_trailer) && (state != ds_err);
	assign rx_tready = take && entries.ready;   // no room in the queue, no word
	assign accept = rx_tvalid && rx_tready;

	////////////////////////////////////////////////////////////////////////////
	// entry on offer to the queue
	always_comb begin
		entries.valid = 1'b0;
		entries.word = rx_data;   // most states forward the receive word
		entries.kind = ek_word;
		entries.last = 1'b0;
		case (state)
			ds_serial: entries.valid = rx_tvalid && !rx_tlast;   // lone serial number dropped
			ds_command: begin
				entries.valid = rx_tvalid;
				entries.last = rx_tlast && (rx_code == cc_loopback);   // empty loopback ends here
			end
			ds_payload: begin
				entries.valid = rx_tvalid;
				entries.last = rx_tlast;
			end
			ds_rd_arg: begin
				entries.valid = rx_tvalid;
				entries.kind = ek_reg_rd;
			end
			ds_wr_num: begin
				entries.valid = rx_tvalid;
				entries.kind = ek_wr_num;
			end
			ds_wr_data: begin
				entries.valid = rx_tvalid;
				entries.kind = ek_wr_data;
			end
			ds_trailer: begin
				entries.valid = 1'b1;
				entries.word = cmd_q;
				entries.kind = ek_trailer;   // responder inverts on error
				entries.last = 1'b1;
			end
			ds_err: begin
				entries.valid = 1'b1;
				entries.word = ~cmd_q;   // bad code or short frame
				entries.last = 1'b1;
			end
			default: entries.valid = 1'b0;   // init and drain push nothing
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// frame parser
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ds_init;
			ended_q <= 1'b0;
		end else begin
			if (accept)
				ended_q <= rx_tlast;
			case (state)
				ds_init: state <= ds_serial;   // one idle cycle out of reset
				ds_serial: if (accept && !rx_tlast) state <= ds_command;
				ds_command: if (accept) begin
					case (rx_code)
						cc_loopback: state <= rx_tlast ? ds_serial : ds_payload;
						cc_rd_reg:   state <= rx_tlast ? ds_err : ds_rd_arg;
						cc_wr_reg:   state <= rx_tlast ? ds_err : ds_wr_num;
						default:     state <= ds_err;
					endcase
				end
				ds_payload, ds_drain: if (accept && rx_tlast) state <= ds_serial;
				ds_rd_arg, ds_wr_data: if (accept) state <= ds_trailer;
				ds_wr_num: if (accept) state <= rx_tlast ? ds_err : ds_wr_data;
				// surplus words of the frame are thrown away
				ds_trailer, ds_err: if (entries.ready) state <= ended_q ? ds_serial : ds_drain;
				default: state <= ds_init;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ds_command && accept)
			cmd_q <= rx_data;
	end

endmodule

// ==== hdl/cmd_queue.sv ====
`timescale 1ns/1ps

module cmd_queue (
	input logic           clk,
	input logic           reset,
	cmd_entry_if.consumer push,
	cmd_entry_if.producer pop
);
	import cmd_pkg::*;

	// entry storage split by field
	word_t       word_mem [queue_depth];
	entry_kind_t kind_mem [queue_depth];
	logic        last_mem [queue_depth];

	logic [$clog2(queue_depth)-1:0] wr_ptr;   // wraps naturally, depth is a power of two
	logic [$clog2(queue_depth)-1:0] rd_ptr;
	logic [$clog2(queue_depth):0]   count;    // entries held
	logic                           do_push;
	logic                           do_pop;

	assign push.ready = (count != queue_depth);   // not full
	assign pop.valid = (count != 0);              // not empty
	assign do_push = push.valid && push.ready;
	assign do_pop = pop.valid && pop.ready;

	// head entry read straight from storage
	assign pop.word = word_mem[rd_ptr];
	assign pop.kind = kind_mem[rd_ptr];
	assign pop.last = last_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			word_mem[wr_ptr] <= push.word;
			kind_mem[wr_ptr] <= push.kind;
			last_mem[wr_ptr] <= push.last;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // both or neither
			endcase
		end
	end

endmodule

// ==== hdl/cmd_responder.sv ====
`timescale 1ns/1ps

module cmd_responder (
	input  logic            clk,
	input  logic            reset,
	cmd_entry_if.consumer   entries,
	reg_access_if.requester regs,
	output cmd_pkg::word_t  tx_data,
	output logic            tx_tvalid,
	output logic            tx_tlast,
	input  logic            tx_tready
);
	import cmd_pkg::*;

	responder_state_t state;       // output register empty or full
	reg_num_t         wr_num_q;    // target of the pending write
	logic             frame_err;   // sticky until the trailer goes out
	logic             pop;
	logic             sends;       // entry produces a transmit word

	assign tx_tvalid = (state == rs_full);

	// take an entry only if the output word is gone or leaving now
	assign entries.ready = !tx_tvalid || tx_tready;
	assign pop = entries.valid && entries.ready;
	assign sends = (entries.kind != ek_wr_num) && (entries.kind != ek_wr_data);

	////////////////////////////////////////////////////////////////////////////
	// register bank access
	assign regs.reg_num = (entries.kind == ek_reg_rd) ? reg_num_t'(entries.word) : wr_num_q;
	assign regs.wr_en = pop && (entries.kind == ek_wr_data);
	assign regs.wr_data = entries.word;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= rs_empty;
			frame_err <= 1'b0;
		end else begin
			if (pop && sends)
				state <= rs_full;
			else if (tx_tready)
				state <= rs_empty;   // word taken, nothing new
			if (pop) begin
				case (entries.kind)
					ek_reg_rd, ek_wr_data: begin
						if (regs.illegal)
							frame_err <= 1'b1;
					end
					ek_trailer: frame_err <= 1'b0;   // next frame starts clean
					default: frame_err <= frame_err;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// output word and write number
	always_ff @(posedge clk) begin
		if (pop) begin
			case (entries.kind)
				ek_word: begin
					tx_data <= entries.word;
					tx_tlast <= entries.last;
				end
				ek_reg_rd: begin
					tx_data <= regs.illegal ? '0 : regs.rd_data;   // zero for a bad number
					tx_tlast <= 1'b0;
				end
				ek_wr_num: wr_num_q <= reg_num_t'(entries.word);
				ek_trailer: begin
					// command word echoed, inverted when the frame failed
					tx_data <= frame_err ? ~entries.word : entries.word;
					tx_tlast <= 1'b1;
				end
				default: tx_tlast <= tx_tlast;   // write data sends nothing
			endcase
		end
	end

endmodule

// ==== hdl/reg_bank.sv ====
`timescale 1ns/1ps

module reg_bank (
	input  logic                  clk,
	input  logic                  reset,
	reg_access_if.bank            access,
	input  cmd_pkg::fill_num_t    fill_num,
	input  cmd_pkg::ch_addr_t     ch_addr,
	output cmd_pkg::tag_t         channel_tag,
	output cmd_pkg::burst_count_t num_muon_bursts,
	output cmd_pkg::burst_count_t num_laser_bursts,
	output cmd_pkg::burst_count_t num_ped_bursts,
	output cmd_pkg::fill_num_t    initial_fill_num,
	output logic                  initial_fill_num_wr
);
	import cmd_pkg::*;

	logic exists;     // number inside the map
	logic writable;   // exists and not an input
	logic wr_ok;

	assign exists = (access.reg_num < num_regs);
	assign writable = exists && (access.reg_num != reg_fill_num)
		&& (access.reg_num != reg_ch_addr);
	assign access.illegal = !exists || (access.wr_en && !writable);
	assign wr_ok = access.wr_en && writable;

	always_ff @(posedge clk) begin
		if (reset) begin
			channel_tag <= '0;
			num_muon_bursts <= '0;
			num_laser_bursts <= '0;
			num_ped_bursts <= '0;
			initial_fill_num <= '0;
			initial_fill_num_wr <= 1'b0;
		end else begin
			// strobe follows the write by one cycle, with the new value
			initial_fill_num_wr <= wr_ok && (access.reg_num == reg_initial_fill);
			if (wr_ok) begin
				case (access.reg_num)
					reg_channel_tag:  channel_tag <= tag_t'(access.wr_data);
					reg_muon_bursts:  num_muon_bursts <= burst_count_t'(access.wr_data);
					reg_laser_bursts: num_laser_bursts <= burst_count_t'(access.wr_data);
					reg_ped_bursts:   num_ped_bursts <= burst_count_t'(access.wr_data);
					default:          initial_fill_num <= fill_num_t'(access.wr_data);
				endcase
			end
		end
	end

	// read mux, upper bits zero
	always_comb begin
		case (access.reg_num)
			reg_channel_tag:  access.rd_data = word_t'(channel_tag);
			reg_muon_bursts:  access.rd_data = word_t'(num_muon_bursts);
			reg_laser_bursts: access.rd_data = word_t'(num_laser_bursts);
			reg_ped_bursts:   access.rd_data = word_t'(num_ped_bursts);
			reg_initial_fill: access.rd_data = word_t'(initial_fill_num);
			reg_fill_num:     access.rd_data = word_t'(fill_num);
			reg_ch_addr:      access.rd_data = word_t'(ch_addr);
			default:          access.rd_data = '0;
		endcase
	end

endmodule

// ==== hdl/command_top.sv ====
`timescale 1ns/1ps

module command_top (
	input  logic                  clk,
	input  logic                  reset,
	// receive stream
	input  cmd_pkg::word_t        rx_data,
	input  logic                  rx_tvalid,
	input  logic                  rx_tlast,
	output logic                  rx_tready,
	// transmit stream
	output cmd_pkg::word_t        tx_data,
	output logic                  tx_tvalid,
	output logic                  tx_tlast,
	input  logic                  tx_tready,
	// acquisition side
	input  cmd_pkg::fill_num_t    fill_num,
	input  cmd_pkg::ch_addr_t     ch_addr,
	output cmd_pkg::tag_t         channel_tag,
	output cmd_pkg::burst_count_t num_muon_bursts,
	output cmd_pkg::burst_count_t num_laser_bursts,
	output cmd_pkg::burst_count_t num_ped_bursts,
	output cmd_pkg::fill_num_t    initial_fill_num,
	output logic                  initial_fill_num_wr
);

	cmd_entry_if  dec_to_queue ();    // decoder pushes here
	cmd_entry_if  queue_to_resp ();   // responder pops here
	reg_access_if reg_bus ();

	////////////////////////////////////////////////////////////////////////////
	cmd_decoder u_decoder (
		.clk       (clk),
		.reset     (reset),
		.rx_data   (rx_data),
		.rx_tvalid (rx_tvalid),
		.rx_tlast  (rx_tlast),
		.rx_tready (rx_tready),
		.entries   (dec_to_queue.producer)
	);

	cmd_queue u_queue (
		.clk   (clk),
		.reset (reset),
		.push  (dec_to_queue.consumer),
		.pop   (queue_to_resp.producer)
	);

	cmd_responder u_responder (
		.clk       (clk),
		.reset     (reset),
		.entries   (queue_to_resp.consumer),
		.regs      (reg_bus.requester),
		.tx_data   (tx_data),
		.tx_tvalid (tx_tvalid),
		.tx_tlast  (tx_tlast),
		.tx_tready (tx_tready)
	);

	reg_bank u_reg_bank (
		.clk                 (clk),
		.reset               (reset),
		.access              (reg_bus.bank),
		.fill_num            (fill_num),
		.ch_addr             (ch_addr),
		.channel_tag         (channel_tag),
		.num_muon_bursts     (num_muon_bursts),
		.num_laser_bursts    (num_laser_bursts),
		.num_ped_bursts      (num_ped_bursts),
		.initial_fill_num    (initial_fill_num),
		.initial_fill_num_wr (initial_fill_num_wr)
	);

endmodule

// ==== tests/command_top_assert.sv ====
`timescale 1ns/1ps

module command_top_assert (
	input logic           clk,
	input logic           reset,
	input logic           rx_tready,
	input cmd_pkg::word_t tx_data,
	input logic           tx_tvalid,
	input logic           tx_tlast,
	input logic           tx_tready,
	input logic           initial_fill_num_wr
);

	int fail_count = 0;   // failed checks so far

	// a stalled transmit word stays put
	hold_tx: assert property (@(posedge clk) disable iff (reset)
		tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_data) && $stable(tx_tlast))
	else begin
		fail_count++;
		$error("transmit word changed while tx_tready was low");
	end

	fill_strobe: assert property (@(posedge clk) disable iff (reset)
		initial_fill_num_wr |=> !initial_fill_num_wr)   // one cycle per write
	else begin
		fail_count++;
		$error("initial_fill_num_wr high for more than one cycle");
	end

	// both streams idle while reset is applied
	quiet_reset: assert property (@(posedge clk) reset |=> !rx_tready && !tx_tvalid)
	else begin
		fail_count++;
		$error("stream handshake active during reset");
	end

endmodule

bind command_top command_top_assert u_assert (
	.clk                 (clk),
	.reset               (reset),
	.rx_tready           (rx_tready),
	.tx_data             (tx_data),
	.tx_tvalid           (tx_tvalid),
	.tx_tlast            (tx_tlast),
	.tx_tready           (tx_tready),
	.initial_fill_num_wr (initial_fill_num_wr)
);

// ==== tests/command_top_tb.sv ====
`timescale 1ns/1ps

module command_top_tb;
	import cmd_pkg::*;

	localparam int max_wait = 400;   // cycles per handshake

	logic         clk = 1'b0;
	logic         reset = 1'b1;
	word_t        rx_data = '0;
	logic         rx_tvalid = 1'b0;
	logic         rx_tlast = 1'b0;
	logic         rx_tready;
	word_t        tx_data;
	logic         tx_tvalid;
	logic         tx_tlast;
	logic         tx_tready = 1'b1;
	fill_num_t    fill_num = '0;
	ch_addr_t     ch_addr = '0;
	tag_t         channel_tag;
	burst_count_t num_muon_bursts;
	burst_count_t num_laser_bursts;
	burst_count_t num_ped_bursts;
	fill_num_t    initial_fill_num;
	logic         initial_fill_num_wr;

	integer seed = 32'hf58720b1;
	logic   random_ready = 1'b0;   // toggle tx_tready each cycle
	word_t  stim_q[$];             // receive words still to send
	logic   stim_last_q[$];
	word_t  exp_q[$];              // transmit words still expected
	logic   exp_last_q[$];
	word_t  model[5];              // writable registers as they should be
	int     fill_pulses = 0;
	int     exp_fill_pulses = 0;

	command_top u_dut (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		#1;
		if (random_ready)
			tx_tready = ($random(seed) & 1) != 0;
	end

	always @(posedge clk)
		if (initial_fill_num_wr)
			fill_pulses <= fill_pulses + 1;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic compare(input string name, input word_t got, input word_t want);
		assert (got === want)
		else stop_run($sformatf("Mismatch on %s: got %h, expected %h", name, got, want));
	endtask

	task automatic push_rx(input word_t w, input logic l);
		stim_q.push_back(w);
		stim_last_q.push_back(l);
	endtask

	task automatic expect_tx(input word_t w, input logic l);
		exp_q.push_back(w);
		exp_last_q.push_back(l);
	endtask

	function automatic word_t make_cmd(input cmd_code_t code);
		word_t w;
		w = $random(seed);   // upper bits are don't care to the engine
		w[4:0] = code;
		return w;
	endfunction

	function automatic word_t field_mask(input word_t num);
		case (num)
			0: return 32'h0000_ffff;         // channel tag
			4: return 32'h00ff_ffff;         // initial fill number
			default: return 32'h001f_ffff;   // burst counts
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// frame builders queue the request and its expected reply
	task automatic loopback_frame(input int n);
		word_t serial;
		word_t cmd;
		word_t w;
		int    i;
		serial = $random(seed);
		cmd = make_cmd(cc_loopback);
		push_rx(serial, 1'b0);
		push_rx(cmd, n == 0);
		expect_tx(serial, 1'b0);
		expect_tx(cmd, n == 0);   // empty loopback ends on the command
		for (i = 0; i < n; i++) begin
			w = $random(seed);
			push_rx(w, i == n - 1);
			expect_tx(w, i == n - 1);
		end
	endtask

	task automatic read_frame(input word_t num);
		word_t serial;
		word_t cmd;
		word_t value;
		serial = $random(seed);
		cmd = make_cmd(cc_rd_reg);
		case (num)
			0, 1, 2, 3, 4: value = model[num[2:0]];
			5: value = {8'h0, fill_num};
			6: value = {29'h0, ch_addr};
			default: value = '0;   // illegal number reads as zero
		endcase
		push_rx(serial, 1'b0);
		push_rx(cmd, 1'b0);
		push_rx(num, 1'b1);
		expect_tx(serial, 1'b0);
		expect_tx(cmd, 1'b0);
		expect_tx(value, 1'b0);
		expect_tx((num < 7) ? cmd : ~cmd, 1'b1);
	endtask

	task automatic write_frame(input word_t num, input word_t data);
		word_t serial;
		word_t cmd;
		serial = $random(seed);
		cmd = make_cmd(cc_wr_reg);
		if (num < 5)
			model[num[2:0]] = data & field_mask(num);
		if (num == 4)
			exp_fill_pulses++;
		push_rx(serial, 1'b0);
		push_rx(cmd, 1'b0);
		push_rx(num, 1'b0);
		push_rx(data, 1'b1);
		expect_tx(serial, 1'b0);
		expect_tx(cmd, 1'b0);
		expect_tx((num < 5) ? cmd : ~cmd, 1'b1);   // inputs 5 and 6 refuse writes
	endtask

	// unknown code or short frame with args words after the command
	task automatic bad_frame(input cmd_code_t code, input int args);
		word_t serial;
		word_t cmd;
		int    i;
		serial = $random(seed);
		cmd = make_cmd(code);
		push_rx(serial, 1'b0);
		push_rx(cmd, args == 0);
		for (i = 0; i < args; i++)
			push_rx($random(seed), i == args - 1);   // surplus or partial arguments
		expect_tx(serial, 1'b0);
		expect_tx(cmd, 1'b0);
		expect_tx(~cmd, 1'b1);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stream drivers
	task automatic send_frame();
		logic l;
		int   waited;
		l = 1'b0;
		while (!l) begin
			l = stim_last_q.pop_front();
			rx_data = stim_q.pop_front();
			rx_tvalid = 1'b1;
			rx_tlast = l;
			waited = 0;
			@(negedge clk);
			while (!rx_tready) begin   // rx_tready only moves on the rising edge
				waited++;
				if (waited > max_wait)
					stop_run("receive stream stalled, rx_tready stayed low");
				@(negedge clk);
			end
			@(posedge clk);   // word taken here
			#1;
		end
		rx_tvalid = 1'b0;
		rx_tlast = 1'b0;
	endtask

	task automatic get_frame();
		logic done;
		int   waited;
		done = 1'b0;
		while (!done) begin
			waited = 0;
			@(negedge clk);
			while (!(tx_tvalid && tx_tready)) begin
				waited++;
				if (waited > max_wait)
					stop_run("no transmit word arrived in time");
				@(negedge clk);
			end
			assert (exp_q.size() > 0)
			else stop_run("transmit word arrived with no reply expected");
			compare("tx_data", tx_data, exp_q.pop_front());
			compare("tx_tlast", word_t'(tx_tlast), word_t'(exp_last_q.pop_front()));
			done = tx_tlast;
			@(posedge clk);   // word leaves on this edge
		end
	endtask

	task automatic run_traffic(input logic toggle_ready);
		random_ready = toggle_ready;
		fork
			while (stim_q.size() > 0) send_frame();
			while (exp_q.size() > 0) get_frame();
		join
		random_ready = 1'b0;
		@(posedge clk);
		#1;
		tx_tready = 1'b1;
	endtask

	task automatic registers_match();
		compare("channel_tag", word_t'(channel_tag), model[0]);
		compare("num_muon_bursts", word_t'(num_muon_bursts), model[1]);
		compare("num_laser_bursts", word_t'(num_laser_bursts), model[2]);
		compare("num_ped_bursts", word_t'(num_ped_bursts), model[3]);
		compare("initial_fill_num", word_t'(initial_fill_num), model[4]);
		compare("initial_fill_num_wr count", word_t'(fill_pulses), word_t'(exp_fill_pulses));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	task automatic reset_values();
		compare("tx_tvalid", word_t'(tx_tvalid), '0);
		compare("rx_tready", word_t'(rx_tready), '0);
		compare("initial_fill_num_wr", word_t'(initial_fill_num_wr), '0);
		registers_match();
	endtask

	task automatic loopback_echo();
		loopback_frame(0);
		loopback_frame(1);
		loopback_frame(6);
		run_traffic(1'b0);
	endtask

	task automatic register_access();
		int num;
		for (num = 0; num < 5; num++) begin
			write_frame(num, $random(seed));
			run_traffic(1'b0);
			registers_match();   // output and strobe count follow the write
			read_frame(num);
			run_traffic(1'b0);
		end
		fill_num = fill_num_t'($random(seed));
		ch_addr = ch_addr_t'($random(seed));
		read_frame(5);
		read_frame(6);
		run_traffic(1'b0);
	endtask

	task automatic error_replies();
		read_frame(7);
		read_frame(32'h8000_0001);
		write_frame(5, $random(seed));
		write_frame(9, $random(seed));
		bad_frame(5'd0, 1);
		bad_frame(5'd31, 2);
		bad_frame(cc_rd_reg, 0);   // ends at the command word
		bad_frame(cc_wr_reg, 0);
		bad_frame(cc_wr_reg, 1);   // number without data
		run_traffic(1'b0);
		registers_match();
	endtask

	task automatic back_to_back_frames();
		word_t pick;
		int    i;
		for (i = 0; i < 14; i++) begin
			pick = $random(seed);
			case (pick[1:0])
				2'd0: loopback_frame(int'(pick[4:2]));
				2'd1: write_frame(word_t'(pick[10:8]) % 6, $random(seed));
				2'd2: read_frame(word_t'(pick[10:8]));
				default: bad_frame(5'd9, 1);
			endcase
		end
		run_traffic(1'b1);   // many frames in flight while ready toggles
		registers_match();
	endtask

	initial begin
		int i;
		for (i = 0; i < 5; i++)
			model[i] = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		reset_values();
		loopback_echo();
		register_access();
		error_replies();
		back_to_back_frames();
		if (u_dut.u_assert.fail_count == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			stop_run("bound concurrent checks failed");
		end
	end

endmodule

// ==== command_engine.f ====
hdl/cmd_pkg.sv
hdl/cmd_entry_if.sv
hdl/reg_access_if.sv
hdl/cmd_decoder.sv
hdl/cmd_queue.sv
hdl/cmd_responder.sv
hdl/reg_bank.sv
hdl/command_top.sv
tests/command_top_assert.sv
tests/command_top_tb.sv

// ==== Makefile ====
# Verilator build and run for the command engine

VERILATOR ?= verilator
TOP       ?= command_top_tb
RTL_TOP   ?= command_top
FILELIST  ?= command_engine.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing --assert -Wall
PASS_TEXT ?= Verification passed

.PHONY: all build sim lint clean

all: sim

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
